/* logic/freq_counter_pkg.sv */
/*
 * frequency counter shared definitions
 * widths, host register map and seven-segment decoding
 */
package freq_counter_pkg;

	// scaled rate in kHz
	localparam int rate_w = 24;
	// display digits and packed bcd
	localparam int digits = 8;
	localparam int bcd_w = 4 * digits;
	// segments a to g, dp left undriven
	localparam int seg_w = 7;

	// host word offsets
	localparam logic [1:0] reg_control = 2'd0;
	localparam logic [1:0] reg_count = 2'd1;
	localparam logic [1:0] reg_rate = 2'd2;
	localparam logic [1:0] reg_bcd = 2'd3;

	// bit order {g,f,e,d,c,b,a}, a zero lights the segment
	function automatic logic [seg_w-1:0] seg_pattern(input logic [3:0] digit);
		case (digit)
			4'd0: seg_pattern = 7'h40;
			4'd1: seg_pattern = 7'h79;
			4'd2: seg_pattern = 7'h24;
			4'd3: seg_pattern = 7'h30;
			4'd4: seg_pattern = 7'h19;
			4'd5: seg_pattern = 7'h12;
			4'd6: seg_pattern = 7'h02;
			4'd7: seg_pattern = 7'h78;
			4'd8: seg_pattern = 7'h00;
			4'd9: seg_pattern = 7'h10;
			// not a decimal digit, so blank
			default: seg_pattern = 7'h7f;
		endcase
	endfunction

endpackage

/* logic/gate_timer.sv */
/*
 * gate timer
 * free-running window generator, gate level plus a close strobe
 */
`timescale 1ns/1ps

module gate_timer #(
	parameter int gate_log2 = 8
) (
	input  logic clock,
	input  logic reset,
	input  logic run,
	output logic gate,
	output logic gate_close
);

	// one extra bit, its msb is the gate
	logic [gate_log2:0] counter;

	always_ff @(posedge clock) begin
		if (reset) begin
			counter <= '0;
			gate_close <= 1'b0;
		end else if (!run) begin
			// stopping drops the gate at once, no close strobe
			counter <= '0;
			gate_close <= 1'b0;
		end else begin
			counter <= counter + 1'b1;
			// wrap from all ones is the falling msb
			gate_close <= &counter;
		end
	end

	// open for the upper half of each period
	assign gate = counter[gate_log2];

endmodule

/* logic/edge_counter.sv */
/*
 * edge counter
 * synchronizes the input and counts rising edges while the gate is open
 */
`timescale 1ns/1ps

module edge_counter #(
	parameter int count_w = 16
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               signal_in,
	input  logic               gate,
	input  logic               gate_close,
	output logic [count_w-1:0] count,
	output logic               count_valid
);

	// two flops against metastability
	logic sync_1;
	logic sync_2;
	// previous synchronized level
	logic level_q;
	logic gate_q;
	logic rise;
	logic [count_w-1:0] running;

	assign rise = sync_2 & ~level_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
			level_q <= 1'b0;
			gate_q <= 1'b0;
			running <= '0;
			count_valid <= 1'b0;
		end else begin
			sync_1 <= signal_in;
			sync_2 <= sync_1;
			level_q <= sync_2;
			gate_q <= gate;
			count_valid <= gate_close;
			if (gate_close) begin
				running <= '0;
			end else if (gate && !gate_q) begin
				// fresh window, drops leftovers of a stopped one
				running <= count_w'(rise);
			end else if (gate && rise && running != '1) begin
				// saturate instead of wrapping
				running <= running + 1'b1;
			end
		end
	end

	// result latched as the window ends
	always_ff @(posedge clock) begin
		if (gate_close) begin
			count <= running;
		end
	end

	assert property (@(posedge clock) disable iff (reset) count_valid |=> !count_valid);

endmodule

/* logic/rate_scaler.sv */
/*
 * rate scaler
 * two-stage pipeline, count times clock kHz over the gate length
 */
`timescale 1ns/1ps

module rate_scaler #(
	parameter int count_w = 16,
	parameter int clock_khz = 25000,
	parameter int gate_log2 = 8
) (
	input  logic                                clock,
	input  logic                                reset,
	input  logic [count_w-1:0]                  count,
	input  logic                                count_valid,
	output logic [freq_counter_pkg::rate_w-1:0] rate,
	output logic                                rate_valid
);

	// full product width, nothing lost before the shift
	localparam int khz_w = $clog2(clock_khz + 1);
	localparam int prod_w = count_w + khz_w;

	logic [prod_w-1:0] product;
	logic product_valid;

	// valid bits follow the data
	always_ff @(posedge clock) begin
		if (reset) begin
			product_valid <= 1'b0;
			rate_valid <= 1'b0;
		end else begin
			product_valid <= count_valid;
			rate_valid <= product_valid;
		end
	end

	// stage one, multiply
	always_ff @(posedge clock) begin
		if (count_valid) begin
			product <= prod_w'(count) * prod_w'(clock_khz);
		end
	end

	// stage two, divide by the window length
	always_ff @(posedge clock) begin
		if (product_valid) begin
			rate <= freq_counter_pkg::rate_w'(product >> gate_log2);
		end
	end

endmodule

/* logic/bin_to_bcd.sv */
/*
 * binary to bcd converter
 * shift-and-add-3, one input bit per clock
 */
`timescale 1ns/1ps

module bin_to_bcd (
	input  logic                                clock,
	input  logic                                reset,
	input  logic [freq_counter_pkg::rate_w-1:0] rate,
	input  logic                                rate_valid,
	output logic [freq_counter_pkg::bcd_w-1:0]  bcd,
	output logic                                bcd_valid
);

	localparam int cnt_w = $clog2(freq_counter_pkg::rate_w);

	logic [freq_counter_pkg::rate_w-1:0] shift_q;
	logic [freq_counter_pkg::bcd_w-1:0] bcd_acc;
	logic [freq_counter_pkg::bcd_w-1:0] adjusted;
	logic [freq_counter_pkg::bcd_w-1:0] next_acc;
	logic [cnt_w-1:0] bit_cnt;
	logic busy;
	logic last;

	// add 3 to any digit of 5 or more before the shift
	for (genvar i = 0; i < freq_counter_pkg::digits; i++) begin : g_digit
		assign adjusted[4*i +: 4] = (bcd_acc[4*i +: 4] >= 4'd5) ?
			bcd_acc[4*i +: 4] + 4'd3 : bcd_acc[4*i +: 4];
		assert property (@(posedge clock) disable iff (reset)
			bcd_valid |-> bcd[4*i +: 4] <= 4'd9);
	end

	// msb of the binary enters at the bottom
	assign next_acc = {adjusted[freq_counter_pkg::bcd_w-2:0],
		shift_q[freq_counter_pkg::rate_w-1]};
	assign last = bit_cnt == cnt_w'(freq_counter_pkg::rate_w - 1);

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			bit_cnt <= '0;
			bcd_valid <= 1'b0;
		end else begin
			bcd_valid <= busy && last;
			if (rate_valid) begin
				busy <= 1'b1;
				bit_cnt <= '0;
			end else if (busy) begin
				bit_cnt <= bit_cnt + 1'b1;
				// done after rate_w shifts
				if (last) begin
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rate_valid) begin
			shift_q <= rate;
			bcd_acc <= '0;
		end else if (busy) begin
			shift_q <= shift_q << 1;
			bcd_acc <= next_acc;
			if (last) begin
				bcd <= next_acc;
			end
		end
	end

	// measurements are far apart, a new input never meets a running one
	assert property (@(posedge clock) disable iff (reset) busy |-> !rate_valid);

endmodule

/* logic/digit_scanner.sv */
/*
 * seven-segment digit scanner
 * drives one common-anode digit at a time from a bcd buffer
 */
`timescale 1ns/1ps

module digit_scanner #(
	parameter int scan_log2 = 4
) (
	input  logic                               clock,
	input  logic                               reset,
	input  logic [freq_counter_pkg::bcd_w-1:0] bcd,
	input  logic                               bcd_valid,
	output logic [freq_counter_pkg::digits-1:0] anode,
	output logic [freq_counter_pkg::seg_w-1:0] cathode
);

	logic [freq_counter_pkg::bcd_w-1:0] buffer;
	// blank until the first result arrives
	logic loaded;
	logic [scan_log2-1:0] dwell;
	logic [3:0] digit;

	always_ff @(posedge clock) begin
		if (reset) begin
			loaded <= 1'b0;
			dwell <= '0;
			anode <= freq_counter_pkg::digits'(1);
		end else begin
			dwell <= dwell + 1'b1;
			if (bcd_valid) begin
				loaded <= 1'b1;
			end
			// rotate to the next digit
			if (&dwell) begin
				anode <= {anode[freq_counter_pkg::digits-2:0],
					anode[freq_counter_pkg::digits-1]};
			end
		end
	end

	always_ff @(posedge clock) begin
		if (bcd_valid) begin
			buffer <= bcd;
		end
	end

	// pick the nibble under the lit anode
	always_comb begin
		digit = '0;
		for (int i = 0; i < freq_counter_pkg::digits; i++) begin
			if (anode[i]) begin
				digit = digit | buffer[4*i +: 4];
			end
		end
	end

	// leading zeros stay lit
	assign cathode = loaded ? freq_counter_pkg::seg_pattern(digit) : '1;

	assert property (@(posedge clock) !reset |-> $onehot(anode));

endmodule

/* logic/wb_status_regs.sv */
/*
 * host register block
 * wishbone classic slave with run control and measurement results
 */
`timescale 1ns/1ps

module wb_status_regs #(
	parameter int count_w = 16
) (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                wb_cyc,
	input  logic                                wb_stb,
	input  logic                                wb_we,
	input  logic [1:0]                          wb_adr,
	input  logic [31:0]                         wb_dat_w,
	output logic [31:0]                         wb_dat_r,
	output logic                                wb_ack,
	input  logic [count_w-1:0]                  count,
	input  logic                                count_valid,
	input  logic [freq_counter_pkg::rate_w-1:0] rate,
	input  logic                                rate_valid,
	input  logic [freq_counter_pkg::bcd_w-1:0]  bcd,
	input  logic                                bcd_valid,
	output logic                                run
);

	logic [15:0] meas_num;
	logic [count_w-1:0] count_q;
	logic [freq_counter_pkg::rate_w-1:0] rate_q;
	logic [freq_counter_pkg::bcd_w-1:0] bcd_q;
	// first cycle of a request, one wait state
	logic accept;

	assign accept = wb_cyc & wb_stb & ~wb_ack;

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_ack <= 1'b0;
			run <= 1'b0;
			meas_num <= '0;
			count_q <= '0;
			rate_q <= '0;
			bcd_q <= '0;
		end else begin
			wb_ack <= accept;
			// only control is writable
			if (accept && wb_we && wb_adr == freq_counter_pkg::reg_control) begin
				run <= wb_dat_w[0];
			end
			// number moves ahead of rate and bcd of the same window
			if (count_valid) begin
				count_q <= count;
				meas_num <= meas_num + 1'b1;
			end
			if (rate_valid) begin
				rate_q <= rate;
			end
			if (bcd_valid) begin
				bcd_q <= bcd;
			end
		end
	end

	// read data captured with the ack
	always_ff @(posedge clock) begin
		if (accept) begin
			case (wb_adr)
				freq_counter_pkg::reg_control: wb_dat_r <= {meas_num, 15'd0, run};
				freq_counter_pkg::reg_count: wb_dat_r <= 32'(count_q);
				freq_counter_pkg::reg_rate: wb_dat_r <= 32'(rate_q);
				default: wb_dat_r <= 32'(bcd_q);
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset) wb_ack |-> wb_cyc && wb_stb);

endmodule

/* logic/freq_counter_top.sv */
/*
 * frequency counter top level
 * gate, edge count, scaling, bcd, display scan and host registers
 */
`timescale 1ns/1ps

module freq_counter_top #(
	parameter int gate_log2 = 8,
	parameter int count_w = 16,
	parameter int clock_khz = 25000,
	parameter int scan_log2 = 4
) (
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic                                 signal_in,
	output logic                                 gate,
	input  logic                                 wb_cyc,
	input  logic                                 wb_stb,
	input  logic                                 wb_we,
	input  logic [1:0]                           wb_adr,
	input  logic [31:0]                          wb_dat_w,
	output logic [31:0]                          wb_dat_r,
	output logic                                 wb_ack,
	output logic [freq_counter_pkg::seg_w-1:0]   cathode,
	output logic [freq_counter_pkg::digits-1:0]  anode
);

	logic run;
	logic gate_close;
	logic [count_w-1:0] count;
	logic count_valid;
	logic [freq_counter_pkg::rate_w-1:0] rate;
	logic rate_valid;
	logic [freq_counter_pkg::bcd_w-1:0] bcd;
	logic bcd_valid;

	gate_timer #(.gate_log2(gate_log2)) i_gate_timer (
		.clock(clock), .reset(reset), .run(run), .gate(gate), .gate_close(gate_close)
	);

	edge_counter #(.count_w(count_w)) i_edge_counter (
		.clock(clock), .reset(reset), .signal_in(signal_in), .gate(gate),
		.gate_close(gate_close), .count(count), .count_valid(count_valid)
	);

	rate_scaler #(
		.count_w(count_w), .clock_khz(clock_khz), .gate_log2(gate_log2)
	) i_rate_scaler (
		.clock(clock), .reset(reset), .count(count), .count_valid(count_valid),
		.rate(rate), .rate_valid(rate_valid)
	);

	bin_to_bcd i_bin_to_bcd (
		.clock(clock), .reset(reset), .rate(rate), .rate_valid(rate_valid),
		.bcd(bcd), .bcd_valid(bcd_valid)
	);

	digit_scanner #(.scan_log2(scan_log2)) i_digit_scanner (
		.clock(clock), .reset(reset), .bcd(bcd), .bcd_valid(bcd_valid),
		.anode(anode), .cathode(cathode)
	);

	wb_status_regs #(.count_w(count_w)) i_wb_status_regs (
		.clock(clock), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.count(count), .count_valid(count_valid), .rate(rate), .rate_valid(rate_valid),
		.bcd(bcd), .bcd_valid(bcd_valid), .run(run)
	);

endmodule

/* tb/freq_counter_checker.sv */
/*
 * frequency counter checker
 * reference model of the measurement chain, checks host reads, gate and display
 */
`timescale 1ns/1ps

module freq_counter_checker #(
	parameter int gate_log2 = 8,
	parameter int clock_khz = 25000,
	parameter int scan_log2 = 4
) (
	input  logic        clock,
	input  logic        reset,
	input  logic        signal_in,
	input  logic        gate,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	input  logic [31:0] wb_dat_r,
	input  logic        wb_ack,
	input  logic [6:0]  cathode,
	input  logic [7:0]  anode,
	output int          mismatches,
	output int          failures
);

	localparam int gate_len = 1 << gate_log2;
	// cycles from a new measurement number until bcd reaches the display
	localparam int settle = freq_counter_pkg::rate_w + 4;

	// synchronizer and edge register model
	logic s1;
	logic s2;
	logic lq;
	logic rise;
	logic gate_prev;
	int running;
	int window_count;
	logic close_seen;
	// host visible registers
	logic [15:0] m_meas;
	int m_count;
	logic [freq_counter_pkg::rate_w-1:0] m_rate;
	logic [31:0] m_bcd;
	logic m_run;
	logic run_prev;
	logic m_loaded;
	// read in flight, expected data taken at accept
	logic accept;
	logic read_open;
	logic [1:0] read_adr;
	logic [31:0] read_exp;
	int phase_len;
	logic phase_valid;
	logic [7:0] anode_prev;
	int dwell;
	int since_update;
	int idx;
	logic [6:0] exp_cathode;

	// decimal digits by repeated division, least significant nibble first
	function automatic logic [31:0] decimal_digits(input int value);
		logic [31:0] r;
		int v;
		v = value;
		for (int i = 0; i < freq_counter_pkg::digits; i++) begin
			r[4*i +: 4] = v % 10;
			v = v / 10;
		end
		return r;
	endfunction

	// lit segments {g,f,e,d,c,b,a}, active high
	function automatic logic [6:0] lit_segments(input logic [3:0] d);
		case (d)
			4'd0: return 7'b0111111;
			4'd1: return 7'b0000110;
			4'd2: return 7'b1011011;
			4'd3: return 7'b1001111;
			4'd4: return 7'b1100110;
			4'd5: return 7'b1101101;
			4'd6: return 7'b1111101;
			4'd7: return 7'b0000111;
			4'd8: return 7'b1111111;
			4'd9: return 7'b1101111;
			default: return 7'b0000000;
		endcase
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			s1 = 1'b0;
			s2 = 1'b0;
			lq = 1'b0;
			gate_prev = 1'b0;
			running = 0;
			close_seen = 1'b0;
			m_meas = '0;
			m_count = 0;
			m_rate = '0;
			m_bcd = '0;
			m_run = 1'b0;
			run_prev = 1'b0;
			m_loaded = 1'b0;
			read_open = 1'b0;
			phase_valid = 1'b0;
			phase_len = 0;
			anode_prev = 8'd1;
			dwell = 0;
			since_update = settle + 1;
		end else begin
			accept = wb_cyc && wb_stb && !wb_ack;
			if (wb_ack && read_open) begin
				read_open = 1'b0;
				if (wb_dat_r !== read_exp) begin
					mismatches++;
					$display("mismatch at %0t: register %0d read %h, expected %h",
						$time, read_adr, wb_dat_r, read_exp);
				end
			end
			if (accept) begin
				read_open = !wb_we;
				read_adr = wb_adr;
				case (wb_adr)
					freq_counter_pkg::reg_control: read_exp = {m_meas, 15'd0, m_run};
					freq_counter_pkg::reg_count: read_exp = 32'(m_count);
					freq_counter_pkg::reg_rate: read_exp = 32'(m_rate);
					default: read_exp = m_bcd;
				endcase
			end
			// window result lands one cycle after the close
			if (close_seen) begin
				close_seen = 1'b0;
				m_meas++;
				m_count = window_count;
				m_rate = (longint'(window_count) * clock_khz) >> gate_log2;
				m_bcd = decimal_digits(int'(m_rate));
				m_loaded = 1'b1;
				since_update = 0;
			end
			// gate opens only if run was set an edge earlier
			if (gate && !run_prev) begin
				failures++;
				$display("gate is open at %0t although run is clear", $time);
			end
			run_prev = m_run;
			if (accept && wb_we && wb_adr == freq_counter_pkg::reg_control) begin
				m_run = wb_dat_w[0];
			end
			// rising edges counted while the gate is high
			rise = s2 && !lq;
			if (gate_prev && !gate) begin
				window_count = running;
				running = 0;
				close_seen = 1'b1;
			end else if (gate && !gate_prev) begin
				running = int'(rise);
			end else if (gate && rise && running < 16'hffff) begin
				running++;
			end
			lq = s2;
			s2 = s1;
			s1 = signal_in;
			// every full gate phase is one window long
			if (gate != gate_prev) begin
				if (phase_valid && phase_len != gate_len) begin
					failures++;
					$display("gate phase of %0d cycles ended at %0t", phase_len, $time);
				end
				phase_valid = 1'b1;
				phase_len = 1;
			end else begin
				phase_len++;
			end
			gate_prev = gate;
			// scan steps one digit per dwell period
			if (!$onehot(anode)) begin
				failures++;
				$display("anode is not one-hot at %0t", $time);
			end
			if (anode != anode_prev) begin
				if (dwell != (1 << scan_log2) || anode != {anode_prev[6:0], anode_prev[7]}) begin
					failures++;
					$display("anode stepped out of turn at %0t", $time);
				end
				dwell = 1;
			end else begin
				dwell++;
			end
			anode_prev = anode;
			if (since_update <= settle) begin
				since_update++;
			end
			idx = 0;
			for (int i = 0; i < freq_counter_pkg::digits; i++) begin
				if (anode[i]) begin
					idx = i;
				end
			end
			// blank until the first result
			exp_cathode = m_loaded ? ~lit_segments(m_bcd[4*idx +: 4]) : 7'h7f;
			if (since_update > settle && cathode !== exp_cathode) begin
				mismatches++;
				$display("mismatch at %0t: digit %0d shows %h, expected %h",
					$time, idx, cathode, exp_cathode);
			end
		end
	end

	initial begin
		mismatches = 0;
		failures = 0;
	end

endmodule

/* tb/freq_counter_tb.sv */
/*
 * frequency counter testbench
 * clock, reset, random input signal and Wishbone host sequence
 */
`timescale 1ns/1ps

module freq_counter_tb;

	localparam int gate_log2 = 8;
	localparam int count_w = 16;
	localparam int clock_khz = 25000;
	localparam int scan_log2 = 4;
	localparam int gate_len = 1 << gate_log2;
	localparam int ack_limit = 16;
	localparam int measurements = 6;

	logic clock;
	logic reset;
	logic signal_in;
	logic gate;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic [6:0] cathode;
	logic [7:0] anode;
	int mismatches;
	int failures;
	logic timed_out;
	logic [31:0] seed;
	int half;
	int toggle_cnt;
	logic [31:0] data;
	logic [15:0] last_meas;

	// 40 ns period
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	freq_counter_top #(
		.gate_log2(gate_log2), .count_w(count_w), .clock_khz(clock_khz), .scan_log2(scan_log2)
	) i_freq_counter_top (
		.clock(clock), .reset(reset), .signal_in(signal_in), .gate(gate),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.cathode(cathode), .anode(anode)
	);

	freq_counter_checker #(
		.gate_log2(gate_log2), .clock_khz(clock_khz), .scan_log2(scan_log2)
	) i_freq_counter_checker (
		.clock(clock), .reset(reset), .signal_in(signal_in), .gate(gate),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.cathode(cathode), .anode(anode), .mismatches(mismatches), .failures(failures)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// input toggles every half cycles
	always @(negedge clock) begin
		if (reset) begin
			toggle_cnt <= 0;
		end else if (toggle_cnt >= half - 1) begin
			signal_in <= ~signal_in;
			toggle_cnt <= 0;
		end else begin
			toggle_cnt <= toggle_cnt + 1;
		end
	end

	// one Wishbone classic cycle, held until ack
	task automatic register_access(input logic we, input logic [1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(negedge clock);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		@(negedge clock);
		while (!wb_ack && !timed_out) begin
			if (waited == ack_limit) begin
				$display("timeout: register block gave no acknowledge for address %0d", adr);
				timed_out = 1'b1;
			end else begin
				waited++;
				@(negedge clock);
			end
		end
		rdata = wb_dat_r;
		// request stays up through the ack cycle
		if (!timed_out) begin
			@(negedge clock);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// poll control until the measurement number moves
	task automatic wait_new_measurement();
		int polls;
		polls = 0;
		register_access(1'b0, freq_counter_pkg::reg_control, '0, data);
		last_meas = data[31:16];
		while (data[31:16] == last_meas && !timed_out) begin
			if (polls == 2 * gate_len) begin
				$display("timeout: measurement number did not advance");
				timed_out = 1'b1;
			end else begin
				polls++;
				register_access(1'b0, freq_counter_pkg::reg_control, '0, data);
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		signal_in = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		timed_out = 1'b0;
		seed = 32'h98a87957;
		seed = lcg_next(seed);
		half = 1 + int'(seed[23:8] % 20);
		repeat (10) @(negedge clock);
		reset = 1'b0;
		// idle for three gate periods, everything reads zero
		repeat (3 * 2 * gate_len) @(negedge clock);
		for (int a = 0; a < 4; a++) begin
			register_access(1'b0, 2'(a), '0, data);
		end
		register_access(1'b1, freq_counter_pkg::reg_control, 32'd1, data);
		for (int m = 0; m < measurements; m++) begin
			wait_new_measurement();
			seed = lcg_next(seed);
			half = 1 + int'(seed[23:8] % 20);
			// rate and bcd trail the measurement number
			repeat (freq_counter_pkg::rate_w + 4) @(negedge clock);
			for (int a = 1; a < 4; a++) begin
				register_access(1'b0, 2'(a), '0, data);
			end
		end
		// stop in the low half of the period, number must stay frozen
		register_access(1'b1, freq_counter_pkg::reg_control, 32'd0, data);
		repeat (4 * 2 * gate_len) @(negedge clock);
		register_access(1'b0, freq_counter_pkg::reg_control, '0, data);
		register_access(1'b0, freq_counter_pkg::reg_count, '0, data);
		$display("errors: %0d mismatches, %0d check failures, %0d timeouts",
			mismatches, failures, timed_out);
		if (mismatches == 0 && failures == 0 && !timed_out) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* vlog.f */
logic/freq_counter_pkg.sv
logic/gate_timer.sv
logic/edge_counter.sv
logic/rate_scaler.sv
logic/bin_to_bcd.sv
logic/digit_scanner.sv
logic/wb_status_regs.sv
logic/freq_counter_top.sv
tb/freq_counter_checker.sv
tb/freq_counter_tb.sv

/* Bender.yml */
package:
  name: freq_counter

sources:
  - logic/freq_counter_pkg.sv
  - logic/gate_timer.sv
  - logic/edge_counter.sv
  - logic/rate_scaler.sv
  - logic/bin_to_bcd.sv
  - logic/digit_scanner.sv
  - logic/wb_status_regs.sv
  - logic/freq_counter_top.sv
  - target: test
    files:
      - tb/freq_counter_checker.sv
      - tb/freq_counter_tb.sv
